/* Bender.yml */
package:
  name: aud_rec_core

sources:
  - include_dirs:
      - design
    files:
      - design/aud_pkg.sv
      - design/aud_recorder.sv
      - design/aud_player.sv
      - design/aud_ctrl.sv
      - design/aud_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/aud_sva.sv
      - tests/aud_tb.sv

/* design/aud_consts.svh */
`ifndef AUD_CONSTS_SVH
`define AUD_CONSTS_SVH

// ==============================
// Sample and memory geometry
// ==============================

// One left-channel sample per frame, sent MSB first
`define AUD_SAMPLE_BITS 16

// External SRAM is addressed in 16-bit words
`define AUD_ADDR_BITS 20

// Default capacity in samples, a little under the full address space
`define AUD_MEM_WORDS 1024000

// ==============================
// Counters
// ==============================

// Must hold the value AUD_SAMPLE_BITS, which marks a finished word
`define AUD_CNT_BITS 5

`endif

/* design/aud_ctrl.sv */
`default_nettype none

module aud_ctrl
    import aud_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_key_record,
    input  logic    i_key_play,
    input  logic    i_key_pause,
    input  logic    i_key_stop,
    input  logic    i_rec_done,
    input  addr_t   i_rec_count,
    input  addr_t   i_rec_address,
    input  sample_t i_rec_data,
    input  logic    i_rec_we_n,
    input  logic    i_play_done,
    input  addr_t   i_play_address,
    output logic    o_rec_start,
    output logic    o_play_start,
    output logic    o_pause,
    output logic    o_stop,
    output addr_t   o_rec_length,
    output addr_t   o_sram_addr,
    output sample_t o_sram_wdata,
    output logic    o_sram_we_n,
    output logic    o_recording,
    output logic    o_playing
);

    mode_e mode_r, mode_w;
    addr_t length_r, length_w;
    logic  rec_start_w, play_start_w;
    logic  pause_r, pause_w;
    logic  stop_w;

    // ==============================
    // Mode and key handling
    // ==============================

    always_comb begin
        mode_w       = mode_r;
        length_w     = length_r;
        pause_w      = pause_r;
        rec_start_w  = 1'b0;
        play_start_w = 1'b0;
        stop_w       = 1'b0;
        case (mode_r)
            mode_idle: begin
                pause_w = 1'b0;
                if (i_key_record) begin
                    mode_w      = mode_record;
                    rec_start_w = 1'b1;
                end else if (i_key_play && length_r != '0) begin
                    mode_w       = mode_play;
                    play_start_w = 1'b1;
                end
            end
            mode_record, mode_play: begin
                if (i_key_pause) pause_w = !pause_r;
                if (i_key_stop) stop_w = 1'b1;
                if (mode_r == mode_record && i_rec_done) begin
                    mode_w   = mode_idle;
                    length_w = i_rec_count;  // Length of the last completed recording
                    pause_w  = 1'b0;
                end
                if (mode_r == mode_play && i_play_done) begin
                    mode_w  = mode_idle;
                    pause_w = 1'b0;
                end
            end
            default: begin
                mode_w = mode_idle;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            mode_r       <= mode_idle;
            length_r     <= '0;
            pause_r      <= 1'b0;
            o_rec_start  <= 1'b0;
            o_play_start <= 1'b0;
            o_stop       <= 1'b0;
        end else begin
            mode_r       <= mode_w;
            length_r     <= length_w;
            pause_r      <= pause_w;
            o_rec_start  <= rec_start_w;
            o_play_start <= play_start_w;
            o_stop       <= stop_w;
        end
    end

    // ==============================
    // SRAM bus owner
    // ==============================

    assign o_sram_addr  = (mode_r == mode_record) ? i_rec_address : i_play_address;
    assign o_sram_wdata = (mode_r == mode_record) ? i_rec_data : '0;
    assign o_sram_we_n  = (mode_r == mode_record) ? i_rec_we_n : 1'b1;  // Reads only outside recording

    assign o_pause      = pause_r;
    assign o_rec_length = length_r;
    assign o_recording  = (mode_r == mode_record);
    assign o_playing    = (mode_r == mode_play);

endmodule

`default_nettype wire

/* design/aud_pkg.sv */
`include "aud_consts.svh"
`default_nettype none

package aud_pkg;

    // ==============================
    // Data types
    // ==============================

    typedef logic [`AUD_SAMPLE_BITS-1:0] sample_t;  // One audio sample
    typedef logic [`AUD_ADDR_BITS-1:0]   addr_t;    // One SRAM word address
    typedef logic [`AUD_CNT_BITS-1:0]    cnt_t;     // Bit position inside a sample

    // ==============================
    // State machines
    // ==============================

    typedef enum logic [2:0] {
        rec_idle,
        rec_wait,       // One cycle between start and the first bit
        rec_record,
        rec_pause,
        rec_finish      // Done follows one cycle later
    } rec_state_e;

    typedef enum logic [1:0] {
        play_idle,
        play_align,     // Waiting for a high i_lrc to load the first word
        play_play,
        play_pause
    } play_state_e;

    typedef enum logic [1:0] {
        mode_idle,
        mode_record,
        mode_play
    } mode_e;

endpackage

`default_nettype wire

/* design/aud_player.sv */
`include "aud_consts.svh"
`default_nettype none

module aud_player
    import aud_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_lrc,
    input  logic    i_start,
    input  logic    i_pause,
    input  logic    i_stop,
    input  addr_t   i_length,
    input  sample_t i_rdata,
    output addr_t   o_address,
    output logic    o_dac_data,
    output logic    o_done
);

    localparam cnt_t cnt_full = cnt_t'(`AUD_SAMPLE_BITS);
    localparam cnt_t cnt_last = cnt_t'(`AUD_SAMPLE_BITS - 1);

    play_state_e state_r, state_w;
    addr_t       address_r, address_w;
    sample_t     shift_r, shift_w;
    cnt_t        bit_cnt_r, bit_cnt_w;
    logic        done_r, done_w;
    logic        active;
    logic        send_bit;
    logic        last_bit;

    assign active   = (state_r == play_play) || (state_r == play_pause);
    assign send_bit = active && !i_lrc && !i_pause && (bit_cnt_r != cnt_full);
    assign last_bit = send_bit && (bit_cnt_r == cnt_last);

    assign o_address  = address_r;
    assign o_dac_data = send_bit && shift_r[`AUD_SAMPLE_BITS-1];  // Zero outside a sent bit
    assign o_done     = done_r;

    // ==============================
    // Next state
    // ==============================

    always_comb begin
        state_w   = state_r;
        address_w = address_r;
        shift_w   = shift_r;
        bit_cnt_w = bit_cnt_r;
        done_w    = 1'b0;
        case (state_r)
            play_idle: begin
                if (i_start) begin
                    state_w   = play_align;
                    address_w = '0;
                    bit_cnt_w = cnt_full;
                end
            end
            play_align: begin
                if (i_stop) begin
                    state_w = play_idle;
                    done_w  = 1'b1;
                end else if (i_lrc) begin
                    state_w   = play_play;
                    shift_w   = i_rdata;
                    bit_cnt_w = '0;
                end
            end
            play_play, play_pause: begin
                state_w = i_pause ? play_pause : play_play;
                if (i_lrc && bit_cnt_r == cnt_full) begin
                    shift_w   = i_rdata;  // Next word is fetched in the high half
                    bit_cnt_w = '0;
                end
                if (send_bit) begin
                    shift_w   = {shift_r[`AUD_SAMPLE_BITS-2:0], 1'b0};
                    bit_cnt_w = bit_cnt_r + 1'b1;
                end
                if (last_bit) begin
                    address_w = address_r + 1'b1;
                end
                if (i_stop || (last_bit && address_w == i_length)) begin
                    state_w = play_idle;
                    done_w  = 1'b1;
                end
            end
            default: begin
                state_w = play_idle;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r   <= play_idle;
            address_r <= '0;
            bit_cnt_r <= '0;
            done_r    <= 1'b0;
        end else begin
            state_r   <= state_w;
            address_r <= address_w;
            bit_cnt_r <= bit_cnt_w;
            done_r    <= done_w;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_r <= shift_w;
    end

endmodule

`default_nettype wire

/* design/aud_recorder.sv */
`include "aud_consts.svh"
`default_nettype none

module aud_recorder
    import aud_pkg::*;
#(
    parameter int P_MEM_WORDS = `AUD_MEM_WORDS
) (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_lrc,
    input  logic    i_start,
    input  logic    i_pause,
    input  logic    i_stop,
    input  logic    i_data,
    output addr_t   o_address,
    output sample_t o_data,
    output logic    o_we_n,
    output logic    o_done,
    output addr_t   o_count
);

    localparam addr_t last_addr = addr_t'(P_MEM_WORDS - 1);
    localparam cnt_t  cnt_full  = cnt_t'(`AUD_SAMPLE_BITS);
    localparam cnt_t  cnt_last  = cnt_t'(`AUD_SAMPLE_BITS - 1);

    rec_state_e state_r, state_w;
    addr_t      address_r, address_w;
    sample_t    data_r, data_w;
    cnt_t       bit_cnt_r, bit_cnt_w;
    logic       we_n_r, we_n_w;
    logic       done_r, done_w;
    logic       active;
    logic       take_bit;

    assign o_address = address_r;
    assign o_data    = data_r;
    assign o_we_n    = we_n_r;
    assign o_done    = done_r;
    assign o_count   = address_r;  // Address always points one past the last written word

    assign active   = (state_r == rec_record) || (state_r == rec_pause);
    assign take_bit = active && !i_lrc && !i_pause && (bit_cnt_r != cnt_full);

    // ==============================
    // Next state
    // ==============================

    always_comb begin
        state_w   = state_r;
        address_w = address_r;
        data_w    = data_r;
        bit_cnt_w = bit_cnt_r;
        we_n_w    = 1'b1;
        done_w    = 1'b0;
        case (state_r)
            rec_idle: begin
                if (i_start) begin
                    state_w   = rec_wait;
                    address_w = '0;
                    bit_cnt_w = '0;
                end
            end
            rec_wait: begin
                state_w = rec_record;
            end
            rec_record, rec_pause: begin
                state_w = i_pause ? rec_pause : rec_record;
                if (take_bit) begin
                    data_w    = {data_r[`AUD_SAMPLE_BITS-2:0], i_data};  // MSB arrives first
                    bit_cnt_w = bit_cnt_r + 1'b1;
                end
                if (!we_n_r) begin
                    address_w = address_r + 1'b1;  // Write cycle ends here
                    bit_cnt_w = '0;
                end
                if (i_stop || (!we_n_r && address_r == last_addr)) begin
                    state_w = rec_finish;  // A partial sample is dropped
                end else if (take_bit && bit_cnt_r == cnt_last) begin
                    we_n_w = 1'b0;
                end
            end
            rec_finish: begin
                state_w = rec_idle;
                done_w  = 1'b1;
            end
            default: begin
                state_w = rec_idle;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r   <= rec_idle;
            address_r <= '0;
            bit_cnt_r <= '0;
            we_n_r    <= 1'b1;
            done_r    <= 1'b0;
        end else begin
            state_r   <= state_w;
            address_r <= address_w;
            bit_cnt_r <= bit_cnt_w;
            we_n_r    <= we_n_w;
            done_r    <= done_w;
        end
    end

    always_ff @(posedge i_clk) begin
        data_r <= data_w;
    end

endmodule

`default_nettype wire

/* design/aud_top.sv */
`include "aud_consts.svh"
`default_nettype none

module aud_top
    import aud_pkg::*;
#(
    parameter int P_MEM_WORDS = `AUD_MEM_WORDS
) (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_key_record,
    input  logic    i_key_play,
    input  logic    i_key_pause,
    input  logic    i_key_stop,
    input  logic    i_lrc,
    input  logic    i_adc_data,
    input  sample_t i_sram_rdata,
    output addr_t   o_sram_addr,
    output sample_t o_sram_wdata,
    output logic    o_sram_we_n,
    output logic    o_dac_data,
    output logic    o_recording,
    output logic    o_playing,
    output addr_t   o_rec_length
);

    logic    rec_start;
    logic    play_start;
    logic    pause;
    logic    stop;
    logic    rec_done;
    addr_t   rec_count;
    addr_t   rec_address;
    sample_t rec_data;
    logic    rec_we_n;
    logic    play_done;
    addr_t   play_address;

    aud_ctrl aud_ctrl_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_key_record   (i_key_record),
        .i_key_play     (i_key_play),
        .i_key_pause    (i_key_pause),
        .i_key_stop     (i_key_stop),
        .i_rec_done     (rec_done),
        .i_rec_count    (rec_count),
        .i_rec_address  (rec_address),
        .i_rec_data     (rec_data),
        .i_rec_we_n     (rec_we_n),
        .i_play_done    (play_done),
        .i_play_address (play_address),
        .o_rec_start    (rec_start),
        .o_play_start   (play_start),
        .o_pause        (pause),
        .o_stop         (stop),
        .o_rec_length   (o_rec_length),
        .o_sram_addr    (o_sram_addr),
        .o_sram_wdata   (o_sram_wdata),
        .o_sram_we_n    (o_sram_we_n),
        .o_recording    (o_recording),
        .o_playing      (o_playing)
    );

    aud_recorder #(
        .P_MEM_WORDS (P_MEM_WORDS)
    ) aud_recorder_inst (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_lrc     (i_lrc),
        .i_start   (rec_start),
        .i_pause   (pause),
        .i_stop    (stop),
        .i_data    (i_adc_data),
        .o_address (rec_address),
        .o_data    (rec_data),
        .o_we_n    (rec_we_n),
        .o_done    (rec_done),
        .o_count   (rec_count)
    );

    aud_player aud_player_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lrc      (i_lrc),
        .i_start    (play_start),
        .i_pause    (pause),
        .i_stop     (stop),
        .i_length   (o_rec_length),
        .i_rdata    (i_sram_rdata),
        .o_address  (play_address),
        .o_dac_data (o_dac_data),
        .o_done     (play_done)
    );

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/aud_pkg.sv
design/aud_recorder.sv
design/aud_player.sv
design/aud_ctrl.sv
design/aud_top.sv
tests/aud_sva.sv
tests/aud_tb.sv

/* tests/aud_sva.sv */
`default_nettype none

module aud_sva
    import aud_pkg::*;
#(
    parameter int P_MEM_WORDS = 64
) (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  addr_t   o_sram_addr,
    input  logic    o_sram_we_n,
    input  logic    o_dac_data,
    input  logic    o_recording,
    input  logic    o_playing,
    input  addr_t   o_rec_length
);

    timeunit 1ns;
    timeprecision 1ps;

    int    fail_count = 0;
    addr_t writes_seen;

    // Counts the writes of the recording in progress
    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            writes_seen <= '0;
        end else if (!o_recording) begin
            writes_seen <= '0;
        end else if (!o_sram_we_n) begin
            writes_seen <= writes_seen + 1'b1;
        end
    end

    // ==============================
    // Reset
    // ==============================

    a_reset_values: assert property (@(posedge i_clk) i_rst_n ##1 i_rst_n |->
            (o_sram_we_n && !o_recording && !o_playing && !o_dac_data && o_rec_length == '0))
        else begin
            fail_count++;
            $error("error %0t: outputs are not at their reset values", $time);
        end

    // ==============================
    // Write order, lengths, DAC
    // ==============================

    a_write_order: assert property (@(posedge i_clk) disable iff (i_rst_n)
            !o_sram_we_n |-> (o_sram_addr == writes_seen && o_sram_addr < P_MEM_WORDS))
        else begin
            fail_count++;
            $error("error %0t: write address %0d, expected %0d", $time, o_sram_addr,
                writes_seen);
        end

    a_length: assert property (@(posedge i_clk) disable iff (i_rst_n)
            $fell(o_recording) |-> o_rec_length == $past(writes_seen))
        else begin
            fail_count++;
            $error("error %0t: recording length %0d does not match the write count", $time,
                o_rec_length);
        end

    a_dac_quiet: assert property (@(posedge i_clk) disable iff (i_rst_n)
            !o_playing |-> !o_dac_data)
        else begin
            fail_count++;
            $error("error %0t: DAC bit high outside playback", $time);
        end

endmodule

bind aud_top aud_sva #(
    .P_MEM_WORDS (P_MEM_WORDS)
) aud_sva_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .o_sram_addr  (o_sram_addr),
    .o_sram_we_n  (o_sram_we_n),
    .o_dac_data   (o_dac_data),
    .o_recording  (o_recording),
    .o_playing    (o_playing),
    .o_rec_length (o_rec_length)
);

`default_nettype wire

/* tests/aud_tb.sv */
`include "aud_consts.svh"
`default_nettype none

module aud_tb
    import aud_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          clk_period   = 8;
    localparam int          mem_words    = 64;
    localparam int          frame_cycles = 32;
    localparam int          low_cycles   = 16;  // i_lrc is low for the first half of a frame
    localparam int          total_frames = 90;
    localparam logic [31:0] lfsr_seed    = 32'he6a3957a;

    logic    i_clk;
    logic    i_rst_n;
    logic    i_key_record;
    logic    i_key_play;
    logic    i_key_pause;
    logic    i_key_stop;
    logic    i_lrc;
    logic    i_adc_data;
    sample_t i_sram_rdata;
    addr_t   o_sram_addr;
    sample_t o_sram_wdata;
    logic    o_sram_we_n;
    logic    o_dac_data;
    logic    o_recording;
    logic    o_playing;
    addr_t   o_rec_length;

    sample_t     mem [0:mem_words-1];
    sample_t     ref_words [0:mem_words-1];
    sample_t     pending_q [$];  // Completed samples waiting for their write
    sample_t     cur_word;
    logic [31:0] lfsr;
    logic        rst_drive, k_rec, k_play, k_pause, k_stop;
    logic        rec_on, paused, play_on, exp_dac;
    logic        rec_s, play_s, dac_s, we_s;
    addr_t       len_s;
    int          cyc, nbits, n_ref, writes, play_idx, play_len;
    int          errors, err_mark, tests;

    aud_top #(
        .P_MEM_WORDS (mem_words)
    ) aud_top_inst (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_key_record (i_key_record), .i_key_play (i_key_play),
        .i_key_pause (i_key_pause), .i_key_stop (i_key_stop),
        .i_lrc (i_lrc), .i_adc_data (i_adc_data), .i_sram_rdata (i_sram_rdata),
        .o_sram_addr (o_sram_addr), .o_sram_wdata (o_sram_wdata),
        .o_sram_we_n (o_sram_we_n), .o_dac_data (o_dac_data),
        .o_recording (o_recording), .o_playing (o_playing), .o_rec_length (o_rec_length)
    );

    // Asynchronous SRAM read
    assign i_sram_rdata = (o_sram_addr < mem_words) ? mem[o_sram_addr] : '0;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int total_errors();
        return errors + aud_top_inst.aud_sva_inst.fail_count;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("error %0t: %s", $time, msg);
    endtask

    // ==============================
    // One codec cycle with the reference model
    // ==============================

    task automatic step();
        @(negedge i_clk);
        lfsr         = lfsr_next(lfsr);
        i_rst_n      = rst_drive;
        i_lrc        = (cyc >= low_cycles);
        i_adc_data   = lfsr[0];
        i_key_record = k_rec;
        i_key_play   = k_play;
        i_key_pause  = k_pause;
        i_key_stop   = k_stop;
        exp_dac      = 1'b0;
        if (cyc < low_cycles) begin
            if (rec_on && !paused) begin
                cur_word = {cur_word[`AUD_SAMPLE_BITS-2:0], lfsr[0]};
                nbits++;
                if (nbits == `AUD_SAMPLE_BITS) begin
                    pending_q.push_back(cur_word);
                    ref_words[n_ref] = cur_word;
                    n_ref++;
                    nbits = 0;
                    if (n_ref == mem_words) rec_on = 1'b0;  // Memory full
                end
            end
            if (play_on && !paused) begin
                exp_dac = ref_words[play_idx][low_cycles - 1 - cyc];
                if (cyc == low_cycles - 1) begin
                    play_idx++;
                    if (play_idx == play_len) play_on = 1'b0;
                end
            end
        end
        // Key effects start with the next cycle
        if (k_pause) paused = !paused;
        if (k_stop) begin
            rec_on = 1'b0;
            nbits  = 0;  // The partial sample is dropped
        end
        if (k_rec) begin
            rec_on = 1'b1;
            nbits  = 0;
            n_ref  = 0;
            writes = 0;
        end
        if (k_play) begin
            play_on  = 1'b1;
            play_idx = 0;
            play_len = n_ref;
        end
        @(posedge i_clk);
        rec_s  = o_recording;
        play_s = o_playing;
        dac_s  = o_dac_data;
        we_s   = o_sram_we_n;
        len_s  = o_rec_length;
        assert (dac_s == exp_dac)
            else report_error($sformatf("DAC bit %0b, expected %0b", dac_s, exp_dac));
        if (!we_s) begin
            assert (pending_q.size() != 0)
                else report_error("a write came with no completed sample pending");
            if (pending_q.size() != 0) begin
                assert (o_sram_wdata == pending_q[0])
                    else report_error($sformatf("written word %h, expected %h",
                        o_sram_wdata, pending_q[0]));
                void'(pending_q.pop_front());
            end
            if (o_sram_addr < mem_words) mem[o_sram_addr] = o_sram_wdata;
            writes++;
        end
        cyc     = (cyc + 1) % frame_cycles;
        k_rec   = 1'b0;
        k_play  = 1'b0;
        k_pause = 1'b0;
        k_stop  = 1'b0;
    endtask

    task automatic skip_to(input int pos);
        while (cyc != pos) step();
    endtask

    task automatic wait_idle();
        do begin
            step();
        end while (rec_s || play_s);
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, total_errors() - err_mark);
        err_mark = total_errors();
        tests++;
    endtask

    initial begin
        i_clk = 1'b0;
        forever #(clk_period / 2) i_clk = ~i_clk;
    end

    initial begin
        #((total_frames * frame_cycles + 10 * frame_cycles) * clk_period);
        $display("timeout, the run did not reach its end in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        i_rst_n = 1'b1;
        {i_key_record, i_key_play, i_key_pause, i_key_stop} = '0;
        {i_lrc, i_adc_data} = '0;
        {rst_drive, k_rec, k_play, k_pause, k_stop} = 5'b10000;
        {rec_on, paused, play_on, exp_dac} = '0;
        lfsr     = lfsr_seed;
        cur_word = '0;
        {cyc, nbits, n_ref, writes, play_idx, play_len} = '0;
        {errors, err_mark, tests} = '0;
        for (int a = 0; a < mem_words; a++) mem[a] = sample_t'(a * 40503) ^ 16'h5a5a;

        repeat (8) step();
        rst_drive = 1'b0;
        repeat (2) step();
        assert (we_s && !rec_s && !play_s && !dac_s && len_s == '0)
            else report_error("outputs are not at their reset values after reset");
        end_test("reset");

        // Two full words, a pause of one frame inside the third, then stop mid-word
        skip_to(20);
        k_rec = 1'b1;
        step();
        skip_to(0);
        repeat (2 * frame_cycles) step();
        skip_to(6);
        k_pause = 1'b1;
        step();
        repeat (frame_cycles - 1) step();
        k_pause = 1'b1;
        step();
        skip_to(0);
        repeat (frame_cycles) step();
        skip_to(5);
        k_stop = 1'b1;
        step();
        wait_idle();
        repeat (frame_cycles) step();  // Any late write shows up here
        assert (len_s == addr_t'(n_ref) && writes == n_ref && pending_q.size() == 0)
            else report_error($sformatf("length %0d and %0d writes, expected %0d words",
                len_s, writes, n_ref));
        end_test("record_pause_stop");

        skip_to(17);
        k_play = 1'b1;
        step();
        skip_to(0);
        skip_to(20);
        k_pause = 1'b1;
        step();
        repeat (frame_cycles - 1) step();
        k_pause = 1'b1;
        step();
        wait_idle();
        assert (!play_on && play_idx == play_len)
            else report_error("playback ended before every recorded word was sent");
        end_test("playback");

        skip_to(20);
        k_rec = 1'b1;
        step();
        wait_idle();
        assert (len_s == addr_t'(mem_words) && writes == mem_words && pending_q.size() == 0)
            else report_error($sformatf("full recording gave length %0d and %0d writes",
                len_s, writes));
        end_test("full_memory");

        $display("tests run %0d, errors %0d", tests, total_errors());
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
